// File: rtl/shaderPkg.sv
//------------------------------
// Shared types for the shading stage
// Fixed-point formats, enums and the record structs
// Reference by scoped names, e.g. shaderPkg::hitRecordT
//------------------------------
package shaderPkg;

    // Fixed-point formats
    localparam int fracBits    = 14;
    localparam int fixedWidth  = 32;
    localparam int normWidth   = 16;
    localparam int bounceWidth = 4;
    localparam int divSteps    = 16;

    typedef logic signed [fixedWidth-1:0] fixedT;
    typedef logic signed [normWidth-1:0]  normT;

    // One and 0.3 in the normalised format
    localparam normT normOne      = 16'sd16384;
    localparam normT ambientLevel = 16'sd4915;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } vec3T;

    typedef struct packed {
        normT x;
        normT y;
        normT z;
    } normVec3T;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgbT;

    typedef enum logic [1:0] {
        surfNone,
        surfLambertian,
        surfMetal
    } surfaceT;

    typedef enum logic [1:0] {
        stIdle,
        stDivide,
        stSend,
        stRelease
    } shadeStateT;

    //------------------------------
    // Records
    //------------------------------
    typedef struct packed {
        logic [9:0]             pixelX;
        logic [9:0]             pixelY;
        surfaceT                surface;
        normVec3T               normal;
        vec3T                   viewDir;
        vec3T                   hitPos;
        rgbT                    color;
        rgbT                    lastColor;
        logic [bounceWidth-1:0] bounceLevel;
        logic                   inShadow;
    } hitRecordT;

    typedef struct packed {
        logic [9:0] pixelX;
        logic [9:0] pixelY;
        rgbT        color;
    } pixelResultT;

    typedef struct packed {
        logic [9:0]             pixelX;
        logic [9:0]             pixelY;
        rgbT                    lastColor;
        logic [bounceWidth-1:0] bounceLevel;
        vec3T                   orig;
        vec3T                   dir;
    } bounceRayT;

    typedef struct packed {
        normVec3T               lightDir;
        logic [bounceWidth-1:0] maxBounce;
    } renderStateT;

endpackage

// File: rtl/colorShade.sv
//------------------------------
// Diffuse plus ambient lighting of one hit
// Scales the surface colour and adds the earlier bounces
// Purely combinational, feeds colorDivide
//------------------------------
`timescale 1ns/1ps

module colorShade (
    input  shaderPkg::hitRecordT record,
    input  shaderPkg::normVec3T  lightDir,
    output logic [2:0][15:0]     sums
);

    logic signed [31:0] prodX, prodY, prodZ;
    logic signed [33:0] diffuse;
    logic signed [33:0] lit;
    logic [15:0]        term;
    logic [2:0][7:0]    colorArr;
    logic [2:0][7:0]    lastArr;
    logic [2:0][7:0]    scaled;

    assign colorArr = record.color;
    assign lastArr  = record.lastColor;

    // Lighting term
    always_comb begin
        prodX = (lightDir.x * record.normal.x) >>> shaderPkg::fracBits;
        prodY = (lightDir.y * record.normal.y) >>> shaderPkg::fracBits;
        prodZ = (lightDir.z * record.normal.z) >>> shaderPkg::fracBits;
        diffuse = prodX + prodY + prodZ;
        // Back-facing or shadowed gives no diffuse light
        if (diffuse < 0 || record.inShadow) begin
            diffuse = '0;
        end
        lit = diffuse + shaderPkg::ambientLevel;
        if (lit > shaderPkg::normOne || record.surface == shaderPkg::surfNone) begin
            term = shaderPkg::normOne;
        end else begin
            term = lit[15:0];
        end
        // Metal keeps a quarter
        if (record.surface == shaderPkg::surfMetal) begin
            term = term >> 2;
        end
    end

    // Per channel scale and accumulate
    always_comb begin
        logic [23:0] scaleProd;
        for (int i = 0; i < 3; i++) begin
            scaleProd = (term * colorArr[i]) >> shaderPkg::fracBits;
            scaled[i] = scaleProd[7:0];
            sums[i]   = lastArr[i] * record.bounceLevel + scaled[i];
        end
    end

endmodule

// File: rtl/colorDivide.sv
//------------------------------
// Restoring divider for the colour average
// Divides three sums by bounceLevel+1, one bit per cycle
// done pulses divSteps+1 cycles after start
//------------------------------
`timescale 1ns/1ps

module colorDivide (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                start,
    input  logic [2:0][15:0]                    sums,
    input  logic [shaderPkg::bounceWidth-1:0]   bounceLevel,
    output logic                                done,
    output shaderPkg::rgbT                      quotient
);

    typedef logic [$clog2(shaderPkg::divSteps + 1)-1:0] countT;

    countT                                   stepCount;
    logic [shaderPkg::bounceWidth:0]         divisor;
    logic [2:0][15:0]                        work, nextWork;
    logic [2:0][shaderPkg::bounceWidth:0]    rem, nextRem;
    logic [2:0][shaderPkg::bounceWidth+1:0]  shifted, diff;
    logic [2:0]                              fits;
    logic [2:0][7:0]                         quoArr;

    // One restoring step per channel
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            shifted[i]  = {rem[i], work[i][15]};
            diff[i]     = shifted[i] - {1'b0, divisor};
            fits[i]     = shifted[i] >= {1'b0, divisor};
            nextRem[i]  = fits[i] ? diff[i][shaderPkg::bounceWidth:0]
                                  : shifted[i][shaderPkg::bounceWidth:0];
            nextWork[i] = {work[i][14:0], fits[i]};
            quoArr[i]   = work[i][7:0];
        end
    end

    assign quotient = quoArr;

    //------------------------------
    // Step counter and done pulse
    //------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            stepCount <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                stepCount <= countT'(shaderPkg::divSteps);
            end else if (stepCount != '0) begin
                stepCount <= stepCount - 1'b1;
                // Last bit goes in on this edge
                if (stepCount == countT'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // Dividend shifts out at the top, quotient bits fill from the bottom
    always_ff @(posedge clk) begin
        if (start) begin
            divisor <= {1'b0, bounceLevel} + 1'b1;
            work    <= sums;
            rem     <= '0;
        end else if (stepCount != '0) begin
            work <= nextWork;
            rem  <= nextRem;
        end
    end

endmodule

// File: rtl/reflectDir.sv
//------------------------------
// Mirror reflection of the view direction
// r = v - 2 * dot(n, v) * n in fixed point, combinational
//------------------------------
`timescale 1ns/1ps

module reflectDir (
    input  shaderPkg::normVec3T normal,
    input  shaderPkg::vec3T     viewDir,
    output shaderPkg::vec3T     dir
);

    // Fixed multiply, result truncated back to 32 bits
    function automatic shaderPkg::fixedT fixedMul(shaderPkg::fixedT a, shaderPkg::fixedT b);
        logic signed [63:0] prod;
        prod = a * b;
        return shaderPkg::fixedT'(prod >>> shaderPkg::fracBits);
    endfunction

    shaderPkg::vec3T  nFixed;
    shaderPkg::fixedT dotNv;
    shaderPkg::fixedT dotTwice;

    // Sign-extend the normal into the general format
    assign nFixed.x = shaderPkg::fixedT'(normal.x);
    assign nFixed.y = shaderPkg::fixedT'(normal.y);
    assign nFixed.z = shaderPkg::fixedT'(normal.z);

    assign dotNv = fixedMul(nFixed.x, viewDir.x)
                 + fixedMul(nFixed.y, viewDir.y)
                 + fixedMul(nFixed.z, viewDir.z);

    assign dotTwice = dotNv <<< 1;

    assign dir.x = viewDir.x - fixedMul(dotTwice, nFixed.x);
    assign dir.y = viewDir.y - fixedMul(dotTwice, nFixed.y);
    assign dir.z = viewDir.z - fixedMul(dotTwice, nFixed.z);

endmodule

// File: rtl/shadeControl.sv
//------------------------------
// Control of the shading stage
// Runs the req/ack handshakes, holds the record and picks
// between a finished pixel and a metal bounce ray
//------------------------------
`timescale 1ns/1ps

module shadeControl (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               inReq,
    input  shaderPkg::hitRecordT               inRecord,
    output logic                               inAck,
    input  logic [shaderPkg::bounceWidth-1:0]  maxBounce,
    output shaderPkg::hitRecordT               record,
    output logic                               divStart,
    input  logic                               divDone,
    input  shaderPkg::rgbT                     quotient,
    input  shaderPkg::vec3T                    reflection,
    output logic                               pixelReq,
    input  logic                               pixelAck,
    output shaderPkg::pixelResultT             pixelOut,
    output logic                               rayReq,
    input  logic                               rayAck,
    output shaderPkg::bounceRayT               rayOut
);

    shaderPkg::shadeStateT state;
    logic                  wantRay;

    assign wantRay = (record.surface == shaderPkg::surfMetal) &&
                     (record.bounceLevel < maxBounce);

    //------------------------------
    // Handshakes and FSM
    //------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= shaderPkg::stIdle;
            inAck    <= 1'b0;
            divStart <= 1'b0;
            pixelReq <= 1'b0;
            rayReq   <= 1'b0;
        end else begin
            divStart <= 1'b0;
            // Input ack follows the source dropping req
            if (inAck && !inReq) begin
                inAck <= 1'b0;
            end
            case (state)
                shaderPkg::stIdle: begin
                    if (inReq && !inAck) begin
                        inAck    <= 1'b1;
                        divStart <= 1'b1;
                        state    <= shaderPkg::stDivide;
                    end
                end
                shaderPkg::stDivide: begin
                    if (divDone) begin
                        pixelReq <= !wantRay;
                        rayReq   <= wantRay;
                        state    <= shaderPkg::stSend;
                    end
                end
                shaderPkg::stSend: begin
                    if ((pixelReq && pixelAck) || (rayReq && rayAck)) begin
                        pixelReq <= 1'b0;
                        rayReq   <= 1'b0;
                        state    <= shaderPkg::stRelease;
                    end
                end
                shaderPkg::stRelease: begin
                    // Wait for the sink to finish its half
                    if (!pixelAck && !rayAck) begin
                        state <= shaderPkg::stIdle;
                    end
                end
                default: state <= shaderPkg::stIdle;
            endcase
        end
    end

    // Record and output payload
    always_ff @(posedge clk) begin
        if (state == shaderPkg::stIdle && inReq && !inAck) begin
            record <= inRecord;
        end
        if (state == shaderPkg::stDivide && divDone) begin
            pixelOut.pixelX <= record.pixelX;
            pixelOut.pixelY <= record.pixelY;
            pixelOut.color  <= quotient;
            rayOut.pixelX      <= record.pixelX;
            rayOut.pixelY      <= record.pixelY;
            rayOut.lastColor   <= quotient;
            rayOut.bounceLevel <= record.bounceLevel + 1'b1;
            rayOut.orig        <= record.hitPos;
            rayOut.dir         <= reflection;
        end
    end

endmodule

// File: rtl/shaderTop.sv
//------------------------------
// Top of the shading stage
// One hit record in, one pixel or bounce ray out
//------------------------------
`timescale 1ns/1ps

module shaderTop (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   inReq,
    input  shaderPkg::hitRecordT   inRecord,
    output logic                   inAck,
    input  shaderPkg::renderStateT renderState,
    output logic                   pixelReq,
    input  logic                   pixelAck,
    output shaderPkg::pixelResultT pixelOut,
    output logic                   rayReq,
    input  logic                   rayAck,
    output shaderPkg::bounceRayT   rayOut
);

    shaderPkg::hitRecordT record;
    shaderPkg::rgbT       quotient;
    shaderPkg::vec3T      reflection;
    logic [2:0][15:0]     sums;
    logic                 divStart;
    logic                 divDone;

    shadeControl control0 (
        .clk        (clk),
        .resetn     (resetn),
        .inReq      (inReq),
        .inRecord   (inRecord),
        .inAck      (inAck),
        .maxBounce  (renderState.maxBounce),
        .record     (record),
        .divStart   (divStart),
        .divDone    (divDone),
        .quotient   (quotient),
        .reflection (reflection),
        .pixelReq   (pixelReq),
        .pixelAck   (pixelAck),
        .pixelOut   (pixelOut),
        .rayReq     (rayReq),
        .rayAck     (rayAck),
        .rayOut     (rayOut)
    );

    // Colour path
    colorShade shade0 (
        .record   (record),
        .lightDir (renderState.lightDir),
        .sums     (sums)
    );

    colorDivide divide0 (
        .clk         (clk),
        .resetn      (resetn),
        .start       (divStart),
        .sums        (sums),
        .bounceLevel (record.bounceLevel),
        .done        (divDone),
        .quotient    (quotient)
    );

    // Reflection path
    reflectDir reflect0 (
        .normal  (record.normal),
        .viewDir (record.viewDir),
        .dir     (reflection)
    );

endmodule

// File: verif/shaderModel.svh
//------------------------------
// Reference model and checking helpers for the shading stage
// Included inside the testbench module, after errorCount and
// currentTest are declared
//------------------------------
`ifndef SHADER_MODEL_SVH
`define SHADER_MODEL_SVH

// Which output a record should leave by, and its payload
typedef struct packed {
    logic                   isRay;
    shaderPkg::pixelResultT pixel;
    shaderPkg::bounceRayT   ray;
} expectT;

function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Fixed-point product kept to 32 bits
function automatic int fixedProduct(input longint a, input longint b);
    return int'((a * b) >>> shaderPkg::fracBits);
endfunction

//------------------------------
// Expected output of one hit record
//------------------------------
function automatic expectT shadeReference(input shaderPkg::hitRecordT rec,
                                          input shaderPkg::renderStateT rs);
    expectT          result;
    longint          diffuse;
    longint          lit;
    int              term;
    int              scaled;
    int              sum;
    int              nx;
    int              ny;
    int              nz;
    int              dotTwice;
    logic [2:0][7:0] colorArr;
    logic [2:0][7:0] lastArr;
    logic [2:0][7:0] average;
    result   = '0;
    colorArr = rec.color;
    lastArr  = rec.lastColor;

    // Lambert term, each axis scaled back before the sum
    diffuse = ((longint'(rs.lightDir.x) * rec.normal.x) >>> shaderPkg::fracBits)
            + ((longint'(rs.lightDir.y) * rec.normal.y) >>> shaderPkg::fracBits)
            + ((longint'(rs.lightDir.z) * rec.normal.z) >>> shaderPkg::fracBits);
    if (diffuse < 0 || rec.inShadow) begin
        diffuse = 0;
    end
    lit = diffuse + shaderPkg::ambientLevel;
    if (rec.surface == shaderPkg::surfNone || lit > shaderPkg::normOne) begin
        term = shaderPkg::normOne;
    end else begin
        term = int'(lit);
    end
    if (rec.surface == shaderPkg::surfMetal) begin
        term = term / 4;
    end

    // Average with the earlier bounces, rounded down
    for (int i = 0; i < 3; i++) begin
        scaled     = (term * colorArr[i]) >>> shaderPkg::fracBits;
        sum        = lastArr[i] * rec.bounceLevel + scaled;
        average[i] = 8'(sum / (rec.bounceLevel + 1));
    end

    // Mirror direction v - 2(n.v)n
    nx       = rec.normal.x;
    ny       = rec.normal.y;
    nz       = rec.normal.z;
    dotTwice = fixedProduct(nx, rec.viewDir.x) + fixedProduct(ny, rec.viewDir.y)
             + fixedProduct(nz, rec.viewDir.z);
    dotTwice = dotTwice * 2;

    result.isRay = (rec.surface == shaderPkg::surfMetal) && (rec.bounceLevel < rs.maxBounce);
    result.pixel.pixelX    = rec.pixelX;
    result.pixel.pixelY    = rec.pixelY;
    result.pixel.color     = average;
    result.ray.pixelX      = rec.pixelX;
    result.ray.pixelY      = rec.pixelY;
    result.ray.lastColor   = average;
    result.ray.bounceLevel = rec.bounceLevel + 1'b1;
    result.ray.orig        = rec.hitPos;
    result.ray.dir.x       = rec.viewDir.x - fixedProduct(dotTwice, nx);
    result.ray.dir.y       = rec.viewDir.y - fixedProduct(dotTwice, ny);
    result.ray.dir.z       = rec.viewDir.z - fixedProduct(dotTwice, nz);
    return result;
endfunction

task automatic compareValue(input string field, input logic [255:0] expected,
                            input logic [255:0] actual);
    if (expected !== actual) begin
        errorCount++;
        $display("error: test %s, %s expected %0h actual %0h",
                 currentTest, field, expected, actual);
    end
endtask

`endif

// File: verif/shaderTb.sv
//------------------------------
// Testbench for the shading stage
// Sends directed and random hit records, acks both outputs with
// random delays and checks every output against the model
//------------------------------
`timescale 1ns/1ps

module shaderTb;

    localparam int clkPeriod  = 10;
    localparam int numRecords = 206;

    logic                   clk;
    logic                   resetn;
    logic                   inReq;
    shaderPkg::hitRecordT   inRecord;
    logic                   inAck;
    shaderPkg::renderStateT renderState;
    logic                   pixelReq;
    logic                   pixelAck;
    shaderPkg::pixelResultT pixelOut;
    logic                   rayReq;
    logic                   rayAck;
    shaderPkg::bounceRayT   rayOut;

    int                     errorCount = 0;
    string                  currentTest = "none";
    int                     testErrors = 0;
    int                     testCount = 0;
    int                     failedTests = 0;
    int                     sentCount = 0;
    int                     checkedCount = 0;
    int                     maxAckDelay = 0;
    logic [31:0]            recRand = 32'hcb3ab063;
    shaderPkg::hitRecordT   expectQ[$];

    `include "shaderModel.svh"

    shaderTop dut0 (
        .clk         (clk),
        .resetn      (resetn),
        .inReq       (inReq),
        .inRecord    (inRecord),
        .inAck       (inAck),
        .renderState (renderState),
        .pixelReq    (pixelReq),
        .pixelAck    (pixelAck),
        .pixelOut    (pixelOut),
        .rayReq      (rayReq),
        .rayAck      (rayAck),
        .rayOut      (rayOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //------------------------------
    // Stimulus helpers
    //------------------------------
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Four-phase send, the record is queued for the checker first
    task automatic sendRecord(input shaderPkg::hitRecordT rec);
        expectQ.push_back(rec);
        sentCount++;
        inRecord = rec;
        inReq    = 1'b1;
        do nextCycle(); while (!inAck);
        inReq = 1'b0;
        do nextCycle(); while (inAck);
    endtask

    function automatic shaderPkg::hitRecordT baseRecord(input shaderPkg::surfaceT surface);
        shaderPkg::hitRecordT rec;
        rec           = '0;
        rec.pixelX    = 10'(sentCount);
        rec.pixelY    = 10'd7;
        rec.surface   = surface;
        rec.normal.y  = 16'sd16384;
        rec.viewDir.x = 32'sd8192;
        rec.viewDir.y = -32'sd16384;
        rec.viewDir.z = 32'sd4096;
        rec.hitPos.x  = 32'sd65536;
        rec.hitPos.y  = 32'sd32768;
        rec.hitPos.z  = -32'sd98304;
        rec.color     = {8'd200, 8'd120, 8'd40};
        rec.lastColor = {8'd90, 8'd60, 8'd30};
        return rec;
    endfunction

    function automatic shaderPkg::hitRecordT randomRecord();
        shaderPkg::hitRecordT rec;
        recRand         = xorshift(recRand);
        rec.pixelX      = recRand[9:0];
        rec.pixelY      = recRand[19:10];
        rec.surface     = shaderPkg::surfaceT'(2'(recRand[31:20] % 3));
        recRand         = xorshift(recRand);
        rec.normal.x    = shaderPkg::normT'($signed(recRand[15:0]) >>> 1);
        rec.normal.y    = shaderPkg::normT'($signed(recRand[31:16]) >>> 1);
        recRand         = xorshift(recRand);
        rec.normal.z    = shaderPkg::normT'($signed(recRand[15:0]) >>> 1);
        rec.bounceLevel = recRand[19:16];
        rec.inShadow    = recRand[20];
        recRand         = xorshift(recRand);
        rec.color       = recRand[23:0];
        recRand         = xorshift(recRand);
        rec.lastColor   = recRand[23:0];
        // Directions within about 8 units, positions within 128
        recRand         = xorshift(recRand);
        rec.viewDir.x   = $signed(recRand) >>> 14;
        recRand         = xorshift(recRand);
        rec.viewDir.y   = $signed(recRand) >>> 14;
        recRand         = xorshift(recRand);
        rec.viewDir.z   = $signed(recRand) >>> 14;
        recRand         = xorshift(recRand);
        rec.hitPos.x    = $signed(recRand) >>> 10;
        recRand         = xorshift(recRand);
        rec.hitPos.y    = $signed(recRand) >>> 10;
        recRand         = xorshift(recRand);
        rec.hitPos.z    = $signed(recRand) >>> 10;
        return rec;
    endfunction

    task automatic beginTest(input string name);
        currentTest = name;
        testErrors  = errorCount;
    endtask

    // Waits until every sent record has been checked
    task automatic finishTest();
        while (checkedCount < sentCount) begin
            nextCycle();
        end
        testCount++;
        if (errorCount == testErrors) begin
            $display("test %s: passed", currentTest);
        end else begin
            failedTests++;
            $display("test %s: failed, %0d errors", currentTest, errorCount - testErrors);
        end
    endtask

    //------------------------------
    // Output sink for both ports
    //------------------------------
    initial begin : outputSink
        logic [31:0] sinkRand;
        int          waitCycles;
        sinkRand = 32'hcb3ab063 ^ 32'h5a5a5a5a;
        pixelAck = 1'b0;
        rayAck   = 1'b0;
        forever begin
            nextCycle();
            if (pixelReq != pixelAck || rayReq != rayAck) begin
                sinkRand   = xorshift(sinkRand);
                waitCycles = sinkRand % (maxAckDelay + 1);
                repeat (waitCycles) nextCycle();
                // Raise on req, drop after req has gone
                pixelAck = pixelReq;
                rayAck   = rayReq;
            end
        end
    end

    //------------------------------
    // Output checker
    //------------------------------
    initial begin : outputCheck
        shaderPkg::hitRecordT   rec;
        expectT                 expected;
        shaderPkg::pixelResultT heldPixel;
        shaderPkg::bounceRayT   heldRay;
        logic                   busy;
        busy = 1'b0;
        forever begin
            nextCycle();
            if (pixelReq && rayReq) begin
                errorCount++;
                $display("test %s: pixelReq and rayReq are high together", currentTest);
            end
            if (!busy && (pixelReq || rayReq)) begin
                busy      = 1'b1;
                heldPixel = pixelOut;
                heldRay   = rayOut;
                if (expectQ.size() == 0) begin
                    errorCount++;
                    $display("test %s: an output came with no record outstanding",
                             currentTest);
                end else begin
                    rec      = expectQ.pop_front();
                    expected = shadeReference(rec, renderState);
                    compareValue("output is ray", expected.isRay, rayReq);
                    if (rayReq) begin
                        compareValue("ray", expected.ray, rayOut);
                    end else begin
                        compareValue("pixel", expected.pixel, pixelOut);
                    end
                end
            end else if (busy && pixelReq) begin
                compareValue("pixel while held", heldPixel, pixelOut);
            end else if (busy && rayReq) begin
                compareValue("ray while held", heldRay, rayOut);
            end else if (busy) begin
                busy = 1'b0;
                checkedCount++;
            end
        end
    end

    // Watchdog, 200 cycles per record
    initial begin
        #(numRecords * 200 * clkPeriod);
        $display("Timeout: the DUT stopped answering in test %s", currentTest);
        $display("Finished with errors");
        $finish;
    end

    //------------------------------
    // Test sequence
    //------------------------------
    initial begin : testSequence
        shaderPkg::hitRecordT rec;
        resetn   = 1'b0;
        inReq    = 1'b0;
        inRecord = '0;
        // Light along (1,1,1) normalised
        renderState.lightDir.x = 16'sd9459;
        renderState.lightDir.y = 16'sd9459;
        renderState.lightDir.z = 16'sd9459;
        renderState.maxBounce  = 4'd3;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        beginTest("reset");
        compareValue("inAck pixelReq rayReq", 3'b000, {inAck, pixelReq, rayReq});
        finishTest();

        beginTest("litLambertian");
        sendRecord(baseRecord(shaderPkg::surfLambertian));
        finishTest();

        beginTest("ambientOnly");
        rec          = baseRecord(shaderPkg::surfLambertian);
        rec.inShadow = 1'b1;
        sendRecord(rec);
        rec          = baseRecord(shaderPkg::surfLambertian);
        rec.normal.y = -16'sd16384;
        sendRecord(rec);
        finishTest();

        beginTest("missAverage");
        rec             = baseRecord(shaderPkg::surfNone);
        rec.bounceLevel = 4'd2;
        sendRecord(rec);
        finishTest();

        beginTest("metalBounce");
        rec             = baseRecord(shaderPkg::surfMetal);
        rec.normal.y    = 16'sd11585;
        rec.normal.z    = 16'sd11585;
        rec.bounceLevel = 4'd1;
        sendRecord(rec);
        finishTest();

        beginTest("metalAtLimit");
        rec             = baseRecord(shaderPkg::surfMetal);
        rec.bounceLevel = 4'd3;
        sendRecord(rec);
        finishTest();

        beginTest("randomRecords");
        maxAckDelay           = 4;
        renderState.maxBounce = 4'd8;
        repeat (200) sendRecord(randomRecord());
        finishTest();

        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verif
rtl/shaderPkg.sv
rtl/colorShade.sv
rtl/colorDivide.sv
rtl/reflectDir.sv
rtl/shadeControl.sv
rtl/shaderTop.sv
verif/shaderTb.sv

// File: run.sh
#!/bin/sh
# Build and run the shading stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module shaderTb -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VshaderTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
